/* hw/load_ctrl.sv */
`timescale 1ns/100ps

module load_ctrl (
   input  logic                    clk_10mhz,
   input  logic                    rst_n,
   input  logic [7:0]              rx_data,
   input  logic                    rx_valid,
   output looper_pkg::mem_wr_t     wr_port,
   output logic                    flsh,
   output logic                    mem_sys_fin,
   output looper_pkg::load_state_e state
);

   logic [2:0]                    byte_cnt;
   logic [looper_pkg::MEM_AW-1:0] word_addr;
   logic [7:0]                    words_left;
   logic [7:0]                    word_cnt;
   logic [looper_pkg::WORD_W-1:0] word_sr;

   //////////////////////////////////////////////////
   // Load FSM
   //////////////////////////////////////////////////

   always_ff @(posedge clk_10mhz or negedge rst_n) begin
      if (!rst_n) begin
         state      <= looper_pkg::ST_IDLE;
         byte_cnt   <= '0;
         word_addr  <= '0;
         words_left <= '0;
         word_cnt   <= '0;
      end else begin
         case (state)
            // Waiting for a count byte, zero means nothing to load
            looper_pkg::ST_IDLE, looper_pkg::ST_RUN: begin
               if (rx_valid && rx_data != 8'd0) begin
                  word_cnt   <= rx_data;
                  words_left <= rx_data;
                  state      <= looper_pkg::ST_COUNT;
               end
            end
            // Count latched, rewind the word pointers
            looper_pkg::ST_COUNT: begin
               word_addr <= '0;
               byte_cnt  <= '0;
               state     <= looper_pkg::ST_BYTES;
            end
            // Collect eight bytes per word
            looper_pkg::ST_BYTES: begin
               if (rx_valid) begin
                  byte_cnt <= byte_cnt + 1'b1;
                  if (byte_cnt == 3'd7) begin
                     state <= looper_pkg::ST_WRITE;
                  end
               end
            end
            // Single write cycle, then next word or done
            looper_pkg::ST_WRITE: begin
               if (words_left == 8'd1) begin
                  state <= looper_pkg::ST_FLUSH;
               end else begin
                  word_addr  <= word_addr + 1'b1;
                  words_left <= words_left - 1'b1;
                  state      <= looper_pkg::ST_BYTES;
               end
            end
            looper_pkg::ST_FLUSH: state <= looper_pkg::ST_RUN;
            default:              state <= looper_pkg::ST_IDLE;
         endcase
      end
   end

   // Byte shifter, MSB first
   always_ff @(posedge clk_10mhz) begin
      if (state == looper_pkg::ST_BYTES && rx_valid) begin
         word_sr <= {word_sr[looper_pkg::WORD_W-9:0], rx_data};
      end
   end

   // Outputs decoded from state
   always_comb begin
      wr_port.en   = (state == looper_pkg::ST_WRITE);
      wr_port.addr = word_addr;
      wr_port.data = word_sr;
   end

   assign flsh        = (state == looper_pkg::ST_FLUSH);
   assign mem_sys_fin = (state == looper_pkg::ST_RUN);

   // Writes stay inside the announced program
   a_wr_in_range: assert property (@(posedge clk_10mhz) disable iff (!rst_n)
      wr_port.en |-> (wr_port.addr < word_cnt));

endmodule

/* hw/loop_fetch.sv */
`timescale 1ns/100ps

module loop_fetch (
   input  logic                          clk_10mhz,
   input  logic                          rst_n,
   input  logic                          flsh,
   input  logic                          mem_sys_fin,
   output logic                          rd_en,
   output logic [looper_pkg::MEM_AW-1:0] rd_addr,
   input  looper_pkg::prog_word_t        rd_data,
   output looper_pkg::fetch_word_t       pc_to_dec
);

   logic [looper_pkg::PC_W-1:0] pc;
   logic                        wait_data;

   // Issue phase reads at pc
   assign rd_en   = mem_sys_fin && !wait_data;
   assign rd_addr = pc[looper_pkg::MEM_AW-1:0];

   //////////////////////////////////////////////////
   // Two-phase fetch
   //////////////////////////////////////////////////

   always_ff @(posedge clk_10mhz or negedge rst_n) begin
      if (!rst_n) begin
         pc        <= '0;
         wait_data <= 1'b0;
         pc_to_dec <= '0;
      end else if (flsh) begin
         // New program, restart at the top
         pc        <= '0;
         wait_data <= 1'b0;
      end else if (!mem_sys_fin) begin
         // Loading, hold what decode sees
         wait_data <= 1'b0;
      end else if (!wait_data) begin
         wait_data <= 1'b1;
      end else begin
         // Data back, pc still names the word just read
         pc_to_dec.pc      <= pc;
         pc_to_dec.payload <= rd_data.payload;
         pc                <= rd_data.next_pc;
         wait_data         <= 1'b0;
      end
   end

   // Links must stay within the memory
   a_pc_in_mem: assert property (@(posedge clk_10mhz) disable iff (!rst_n)
      pc[looper_pkg::PC_W-1:looper_pkg::MEM_AW] == '0);

endmodule

/* hw/looper_board.sv */
`timescale 1ns/100ps

module looper_board (
   input  logic                    clk_10mhz,
   input  logic                    rst_n,
   input  logic                    rxd,
   input  logic [1:0]              br_cfg,
   output looper_pkg::load_state_e state,
   output looper_pkg::fetch_word_t pc_to_dec,
   output logic                    mem_sys_fin,
   output logic                    gpio_led_4,
   output logic                    gpio_led_5,
   output logic                    gpio_led_6
);

   // Serial side
   logic [7:0]                    rx_data;
   logic                          rx_valid;
   // Loader to memory and fetch
   looper_pkg::mem_wr_t           wr_port;
   logic                          flsh;
   // Fetch to memory
   logic                          rd_en;
   logic [looper_pkg::MEM_AW-1:0] rd_addr;
   looper_pkg::prog_word_t        rd_data;

   //////////////////////////////////////////////////
   // Program load path
   //////////////////////////////////////////////////

   uart_rx uart_rx_i (
      .clk_10mhz (clk_10mhz),
      .rst_n     (rst_n),
      .rxd       (rxd),
      .br_cfg    (br_cfg),
      .rx_data   (rx_data),
      .rx_valid  (rx_valid)
   );

   load_ctrl load_ctrl_i (
      .clk_10mhz   (clk_10mhz),
      .rst_n       (rst_n),
      .rx_data     (rx_data),
      .rx_valid    (rx_valid),
      .wr_port     (wr_port),
      .flsh        (flsh),
      .mem_sys_fin (mem_sys_fin),
      .state       (state)
   );

   prog_mem prog_mem_i (
      .clk_10mhz (clk_10mhz),
      .wr_port   (wr_port),
      .rd_en     (rd_en),
      .rd_addr   (rd_addr),
      .rd_data   (rd_data)
   );

   //////////////////////////////////////////////////
   // Run path
   //////////////////////////////////////////////////

   loop_fetch loop_fetch_i (
      .clk_10mhz   (clk_10mhz),
      .rst_n       (rst_n),
      .flsh        (flsh),
      .mem_sys_fin (mem_sys_fin),
      .rd_en       (rd_en),
      .rd_addr     (rd_addr),
      .rd_data     (rd_data),
      .pc_to_dec   (pc_to_dec)
   );

   pc_status_leds pc_status_leds_i (
      .clk_10mhz  (clk_10mhz),
      .rst_n      (rst_n),
      .pc_to_dec  (pc_to_dec),
      .gpio_led_4 (gpio_led_4),
      .gpio_led_5 (gpio_led_5),
      .gpio_led_6 (gpio_led_6)
   );

endmodule

/* hw/looper_pkg.sv */
package looper_pkg;

   //////////////////////////////////////////////////
   // Sizes
   //////////////////////////////////////////////////

   // Program memory geometry
   localparam int MEM_AW    = 8;
   localparam int MEM_DEPTH = 256;

   // Program word split: link on top, payload below
   localparam int WORD_W    = 64;
   localparam int PC_W      = 16;
   localparam int PAYLOAD_W = WORD_W - PC_W;

   // Clocks per serial bit at 10 MHz, by br_cfg
   // 4800, 9600, 19200, 38400 baud
   localparam int DIV_W               = 12;
   localparam int BAUD_DIV [4]        = '{2083, 1042, 521, 260};

   //////////////////////////////////////////////////
   // Bundles
   //////////////////////////////////////////////////

   // One write into program memory
   typedef struct packed {
      logic              en;
      logic [MEM_AW-1:0] addr;
      logic [WORD_W-1:0] data;
   } mem_wr_t;

   // Stored word, next address first
   typedef struct packed {
      logic [PC_W-1:0]      next_pc;
      logic [PAYLOAD_W-1:0] payload;
   } prog_word_t;

   // Word handed to decode
   typedef struct packed {
      logic [PC_W-1:0]      pc;
      logic [PAYLOAD_W-1:0] payload;
   } fetch_word_t;

   // Loader states, also exported on the board pins
   typedef enum logic [3:0] {
      ST_IDLE  = 4'd0,
      ST_COUNT = 4'd1,
      ST_BYTES = 4'd2,
      ST_WRITE = 4'd3,
      ST_FLUSH = 4'd4,
      ST_RUN   = 4'd5
   } load_state_e;

endpackage

/* hw/pc_status_leds.sv */
`timescale 1ns/100ps

module pc_status_leds (
   input  logic                    clk_10mhz,
   input  logic                    rst_n,
   input  looper_pkg::fetch_word_t pc_to_dec,
   output logic                    gpio_led_4,
   output logic                    gpio_led_5,
   output logic                    gpio_led_6
);

   //////////////////////////////////////////////////
   // LED decode
   //////////////////////////////////////////////////

   // All dark in reset
   always_ff @(posedge clk_10mhz or negedge rst_n) begin
      if (!rst_n) begin
         gpio_led_4 <= 1'b0;
         gpio_led_5 <= 1'b0;
         gpio_led_6 <= 1'b0;
      end else begin
         // Past the first few words
         gpio_led_4 <= (pc_to_dec.pc > 16'd3);
         // At loop head
         gpio_led_5 <= (pc_to_dec.pc == 16'd0);
         // Anywhere else
         gpio_led_6 <= (pc_to_dec.pc > 16'd0);
      end
   end

endmodule

/* hw/prog_mem.sv */
`timescale 1ns/100ps

module prog_mem (
   input  logic                          clk_10mhz,
   input  looper_pkg::mem_wr_t           wr_port,
   input  logic                          rd_en,
   input  logic [looper_pkg::MEM_AW-1:0] rd_addr,
   output looper_pkg::prog_word_t        rd_data
);

   // Block RAM array
   looper_pkg::prog_word_t mem [looper_pkg::MEM_DEPTH];

   //////////////////////////////////////////////////
   // Ports
   //////////////////////////////////////////////////

   // Write side, from the loader
   always_ff @(posedge clk_10mhz) begin
      if (wr_port.en) begin
         mem[wr_port.addr] <= looper_pkg::prog_word_t'(wr_port.data);
      end
   end

   // Read side, one cycle latency
   always_ff @(posedge clk_10mhz) begin
      if (rd_en) begin
         rd_data <= mem[rd_addr];
      end
   end

   // Fetch and load never touch the same word together
   a_no_rw_clash: assert property (@(posedge clk_10mhz)
      (rd_en && wr_port.en) |-> (rd_addr != wr_port.addr));

endmodule

/* hw/uart_rx.sv */
`timescale 1ns/100ps

module uart_rx (
   input  logic       clk_10mhz,
   input  logic       rst_n,
   input  logic       rxd,
   input  logic [1:0] br_cfg,
   output logic [7:0] rx_data,
   output logic       rx_valid
);

   logic                         rxd_meta;
   logic                         rxd_sync;
   logic                         busy;
   logic [3:0]                   bit_idx;
   logic [looper_pkg::DIV_W-1:0] div_cnt;
   logic [looper_pkg::DIV_W-1:0] bit_div;
   logic [7:0]                   shift_sr;

   // Clocks per bit for the selected rate
   assign bit_div = looper_pkg::DIV_W'(looper_pkg::BAUD_DIV[br_cfg]);

   // Two-flop synchroniser, idles high like the line
   always_ff @(posedge clk_10mhz or negedge rst_n) begin
      if (!rst_n) begin
         rxd_meta <= 1'b1;
         rxd_sync <= 1'b1;
      end else begin
         rxd_meta <= rxd;
         rxd_sync <= rxd_meta;
      end
   end

   //////////////////////////////////////////////////
   // Frame control
   //////////////////////////////////////////////////

   // bit_idx 0 is the start bit, 1..8 data, 9 stop
   always_ff @(posedge clk_10mhz or negedge rst_n) begin
      if (!rst_n) begin
         busy     <= 1'b0;
         bit_idx  <= '0;
         div_cnt  <= '0;
         rx_valid <= 1'b0;
      end else begin
         rx_valid <= 1'b0;
         if (!busy) begin
            // Falling edge seen, wait half a bit to land mid start bit
            if (!rxd_sync) begin
               busy    <= 1'b1;
               bit_idx <= '0;
               div_cnt <= (bit_div >> 1) - 1'b1;
            end
         end else if (div_cnt != '0) begin
            div_cnt <= div_cnt - 1'b1;
         end else begin
            // Sample point
            div_cnt <= bit_div - 1'b1;
            bit_idx <= bit_idx + 1'b1;
            if (bit_idx == 4'd0 && rxd_sync) begin
               busy <= 1'b0;  // start bit gone high again, just a glitch
            end else if (bit_idx == 4'd9) begin
               busy     <= 1'b0;
               // Framing error gives no strobe
               rx_valid <= rxd_sync;
            end
         end
      end
   end

   // Data bits arrive LSB first
   always_ff @(posedge clk_10mhz) begin
      if (busy && div_cnt == '0) begin
         if (bit_idx >= 4'd1 && bit_idx <= 4'd8) begin
            shift_sr <= {rxd_sync, shift_sr[7:1]};
         end
         if (bit_idx == 4'd9) begin
            rx_data <= shift_sr;
         end
      end
   end

endmodule

/* looper_board.f */
hw/looper_pkg.sv
hw/uart_rx.sv
hw/load_ctrl.sv
hw/prog_mem.sv
hw/loop_fetch.sv
hw/pc_status_leds.sv
hw/looper_board.sv
verif/looper_board_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build the looper board testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
   --top-module looper_board_tb \
   --Mdir obj_dir \
   -f looper_board.f
if [ $? -ne 0 ]; then
   echo "Verilator build failed"
   exit 1
fi

./obj_dir/Vlooper_board_tb
status=$?
if [ $status -ne 0 ]; then
   echo "Simulation ended with status $status"
   exit $status
fi

echo "Simulation ended cleanly"
exit 0

/* verif/looper_board_tb.sv */
`timescale 1ns/100ps

module looper_board_tb;

   localparam int N_ROWS = 4;
   localparam int STEPS  = 6;

   // DUT ports
   logic                    clk_10mhz = 1'b0;
   logic                    rst_n;
   logic                    rxd;
   logic [1:0]              br_cfg;
   looper_pkg::load_state_e state;
   looper_pkg::fetch_word_t pc_to_dec;
   logic                    mem_sys_fin;
   logic                    gpio_led_4;
   logic                    gpio_led_5;
   logic                    gpio_led_6;

   // Run length guard
   int cycle_cnt = 0;
   int cycle_limit;

   // Clocks per serial bit at 10 MHz for 4800 up to 38400 baud
   int bit_clocks [4] = '{2083, 1042, 521, 260};

   //////////////////////////////////////////////////
   // Program table
   //////////////////////////////////////////////////

   // Word k goes to address k with next_pc in the top 16 bits
   string      row_name [N_ROWS] = '{"loop3_br1", "leds_br3", "loop2_br2", "loop4_br0"};
   logic [1:0] row_br   [N_ROWS] = '{2'd1, 2'd3, 2'd2, 2'd0};
   int         row_cnt  [N_ROWS] = '{3, 6, 2, 4};
   looper_pkg::prog_word_t row_word [N_ROWS][STEPS] = '{
      // 0 -> 1 -> 2 -> 0
      '{64'h0001_c0de_0000_0100, 64'h0002_c0de_0000_0101, 64'h0000_c0de_0000_0102,
        64'h0, 64'h0, 64'h0},
      // 0 -> 2 -> 5 -> 0
      // Words 1 3 4 never visited
      '{64'h0002_beef_0000_0200, 64'h0003_beef_0000_0201, 64'h0005_beef_0000_0202,
        64'h0004_beef_0000_0203, 64'h0001_beef_0000_0204, 64'h0000_beef_0000_0205},
      // Two word ping-pong
      '{64'h0001_face_0000_0300, 64'h0000_face_0000_0301,
        64'h0, 64'h0, 64'h0, 64'h0},
      // 0 -> 3 -> 1 -> 2 -> 0
      '{64'h0003_d00d_0000_0400, 64'h0002_d00d_0000_0401, 64'h0000_d00d_0000_0402,
        64'h0001_d00d_0000_0403, 64'h0, 64'h0}
   };
   // PC order seen by decode
   int row_pc [N_ROWS][STEPS] = '{
      '{0, 1, 2, 0, 1, 2},
      '{0, 2, 5, 0, 2, 5},
      '{0, 1, 0, 1, 0, 1},
      '{0, 3, 1, 2, 0, 3}
   };

   looper_board looper_board_i (
      .clk_10mhz   (clk_10mhz),
      .rst_n       (rst_n),
      .rxd         (rxd),
      .br_cfg      (br_cfg),
      .state       (state),
      .pc_to_dec   (pc_to_dec),
      .mem_sys_fin (mem_sys_fin),
      .gpio_led_4  (gpio_led_4),
      .gpio_led_5  (gpio_led_5),
      .gpio_led_6  (gpio_led_6)
   );

   // 100 ns period
   always #50 clk_10mhz = ~clk_10mhz;

   //////////////////////////////////////////////////
   // Helpers
   //////////////////////////////////////////////////

   task automatic abort_run(input string what);
      $display("%s", what);
      $display("CHECKS FAILED");
      $fatal(1, "run stopped at first error");
   endtask

   // 8N1 frame sent LSB first
   // One divisor of clocks per bit
   task automatic send_byte(input logic [7:0] data, input int div);
      logic [9:0] frame;
      frame = {1'b1, data, 1'b0};
      for (int b = 0; b < 10; b++) begin
         rxd <= frame[b];
         repeat (div) @(posedge clk_10mhz);
      end
   endtask

   // Count byte then each word MSB first
   task automatic send_program(input int r);
      int          div;
      logic [63:0] word;
      div = bit_clocks[row_br[r]];
      send_byte(8'(row_cnt[r]), div);
      for (int k = 0; k < row_cnt[r]; k++) begin
         word = row_word[r][k];
         for (int b = 7; b >= 0; b--) begin
            send_byte(word[8*b +: 8], div);
         end
      end
   endtask

   task automatic run_and_check(input int r);
      looper_pkg::fetch_word_t frozen;
      looper_pkg::fetch_word_t prev;
      logic [2:0]              exp_led;
      int                      cur_pc;
      int                      step;
      // A running program stops once the count byte lands
      while (mem_sys_fin) @(posedge clk_10mhz);
      frozen = pc_to_dec;
      // Decode output frozen for the whole load
      while (!mem_sys_fin) begin
         @(posedge clk_10mhz);
         assert (pc_to_dec === frozen) else abort_run($sformatf(
            "FAIL %s hold: expected %h actual %h", row_name[r], frozen, pc_to_dec));
      end
      assert (state === looper_pkg::ST_RUN) else abort_run($sformatf(
         "FAIL %s state: expected %0d actual %0d", row_name[r], looper_pkg::ST_RUN, state));
      prev   = pc_to_dec;
      cur_pc = 0;
      step   = 0;
      while (step < STEPS) begin
         @(posedge clk_10mhz);
         if (pc_to_dec !== prev) begin
            // Listed order from the table
            assert (pc_to_dec.pc === 16'(row_pc[r][step])) else abort_run($sformatf(
               "FAIL %s step %0d listed pc: expected %0d actual %0d",
               row_name[r], step, row_pc[r][step], pc_to_dec.pc));
            // Model walks the links from 0
            assert (pc_to_dec.pc === 16'(cur_pc)) else abort_run($sformatf(
               "FAIL %s step %0d pc: expected %0d actual %0d",
               row_name[r], step, cur_pc, pc_to_dec.pc));
            assert (pc_to_dec.payload === row_word[r][cur_pc].payload) else abort_run(
               $sformatf("FAIL %s step %0d payload: expected %h actual %h", row_name[r],
               step, row_word[r][cur_pc].payload, pc_to_dec.payload));
            prev = pc_to_dec;
            // LEDs lag one clock
            @(posedge clk_10mhz);
            exp_led = {cur_pc > 3, cur_pc == 0, cur_pc > 0};
            assert ({gpio_led_4, gpio_led_5, gpio_led_6} === exp_led) else abort_run(
               $sformatf("FAIL %s step %0d leds 4/5/6: expected %b actual %b", row_name[r],
               step, exp_led, {gpio_led_4, gpio_led_5, gpio_led_6}));
            cur_pc = int'(row_word[r][cur_pc].next_pc);
            step++;
         end
      end
   endtask

   //////////////////////////////////////////////////
   // Timeout
   //////////////////////////////////////////////////

   always @(posedge clk_10mhz) begin
      cycle_cnt <= cycle_cnt + 1;
      if (cycle_cnt > cycle_limit) begin
         abort_run($sformatf("Timeout, run still going after %0d clock cycles", cycle_limit));
      end
   end

   //////////////////////////////////////////////////
   // Main sequence
   //////////////////////////////////////////////////

   initial begin
      rst_n  <= 1'b0;
      rxd    <= 1'b1;
      br_cfg <= 2'd0;
      // Serial time of every load plus slack
      cycle_limit = 2000;
      for (int r = 0; r < N_ROWS; r++) begin
         cycle_limit += (1 + 8 * row_cnt[r]) * 10 * bit_clocks[row_br[r]];
      end
      repeat (2) @(posedge clk_10mhz);
      rst_n <= 1'b1;
      @(posedge clk_10mhz);
      // Reset values
      assert (state === looper_pkg::ST_IDLE) else abort_run($sformatf(
         "FAIL reset state: expected %0d actual %0d", looper_pkg::ST_IDLE, state));
      assert (mem_sys_fin === 1'b0) else abort_run($sformatf(
         "FAIL reset mem_sys_fin: expected 0 actual %b", mem_sys_fin));
      assert (pc_to_dec === '0) else abort_run($sformatf(
         "FAIL reset pc_to_dec: expected 0 actual %h", pc_to_dec));
      assert ({gpio_led_4, gpio_led_5, gpio_led_6} === 3'b000) else abort_run($sformatf(
         "FAIL reset leds: expected 000 actual %b", {gpio_led_4, gpio_led_5, gpio_led_6}));
      // Each later row reloads over a running program
      for (int r = 0; r < N_ROWS; r++) begin
         br_cfg <= row_br[r];
         @(posedge clk_10mhz);
         fork
            send_program(r);
            run_and_check(r);
         join
      end
      $display("ALL CHECKS PASSED");
      $finish;
   end

endmodule
